// File: list.f
+incdir+include
src/isa_pkg.sv
src/core_pkg.sv
src/decode_unit.sv
src/execute_unit.sv
src/register_file.sv
src/pc_unit.sv
src/unified_memory.sv
src/rv_core.sv
test/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter the project directory"
  exit 1
fi

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
  --top-module rv_core_tb -Mdir "$BUILD_DIR" -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/rv_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: src/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int MEM_WORDS  = 256;
  localparam int MEM_ADDR_W = 8; // word index, byte address bits 9:2

  // zero encodings double as the inactive bundle
  typedef enum logic [3:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    SLL    = 4'd2,
    SRL    = 4'd3,
    SRA    = 4'd4,
    AND    = 4'd5,
    OR     = 4'd6,
    XOR    = 4'd7,
    PASS_B = 4'd8
  } alu_op_t;

  typedef enum logic [2:0] {
    NONE = 3'd0,
    BEQ  = 3'd1,
    BNE  = 3'd2,
    BLT  = 3'd3,
    BGE  = 3'd4,
    BLTU = 3'd5,
    BGEU = 3'd6
  } branch_t;

  typedef enum logic [1:0] {
    ALU  = 2'd0,
    MEM  = 2'd1,
    LINK = 2'd2
  } wb_sel_t;

  typedef struct packed {
    alu_op_t alu_op;
    branch_t branch;
    logic    use_imm;    // operand b from immediate
    logic    pc_operand; // operand a from pc, auipc
    logic    jump;
    logic    jump_reg;
    logic    mem_read;
    logic    mem_write;
    logic    byte_access;
    logic    reg_write;
    wb_sel_t wb_sel;
  } ctrl_t;

  typedef struct packed {
    logic                     we;
    logic [MEM_ADDR_W-1:0]    addr;
    logic [isa_pkg::XLEN-1:0] data;
  } prog_t;

  typedef struct packed {
    logic                     valid;
    logic [isa_pkg::XLEN-1:0] pc;
    logic [REG_ADDR_W-1:0]    rd;
    logic [isa_pkg::XLEN-1:0] data;
  } retire_t;

endpackage

`default_nettype wire

// File: src/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
  input  wire isa_pkg::inst_u              inst,
  output logic [core_pkg::REG_ADDR_W-1:0] rs1,
  output logic [core_pkg::REG_ADDR_W-1:0] rs2,
  output logic [core_pkg::REG_ADDR_W-1:0] rd,
  output logic [isa_pkg::XLEN-1:0]        imm,
  output core_pkg::ctrl_t                 ctrl
);

  logic                     sign;
  logic                     f7_base;
  logic                     f7_alt;
  logic                     known;
  logic                     has_rd;
  core_pkg::ctrl_t          c;
  logic [isa_pkg::XLEN-1:0] imm_i;
  logic [isa_pkg::XLEN-1:0] imm_s;
  logic [isa_pkg::XLEN-1:0] imm_b;
  logic [isa_pkg::XLEN-1:0] imm_u;
  logic [isa_pkg::XLEN-1:0] imm_j;

  assign sign    = inst.raw[isa_pkg::XLEN-1]; // same sign bit in every format
  assign f7_base = inst.r.funct7 == isa_pkg::F7_BASE;
  assign f7_alt  = inst.r.funct7 == isa_pkg::F7_ALT;

  assign imm_i = {{20{sign}}, inst.i.imm};
  assign imm_s = {{20{sign}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{19{sign}}, inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5,
                  inst.b.imm_4_1, 1'b0};
  assign imm_u = {inst.u.imm, 12'b0};
  assign imm_j = {{11{sign}}, inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11,
                  inst.j.imm_10_1, 1'b0};

  always_comb begin
    c      = '0;
    known  = 1'b1;
    has_rd = 1'b0;
    imm    = '0;
    case (inst.r.opcode)
      isa_pkg::OP: begin
        c.reg_write = 1'b1;
        has_rd      = 1'b1;
        case (inst.r.funct3)
          isa_pkg::F3_ADD: c.alu_op = f7_alt ? core_pkg::SUB : core_pkg::ADD;
          isa_pkg::F3_SLL: c.alu_op = core_pkg::SLL;
          isa_pkg::F3_XOR: c.alu_op = core_pkg::XOR;
          isa_pkg::F3_SRL: c.alu_op = f7_alt ? core_pkg::SRA : core_pkg::SRL;
          isa_pkg::F3_OR:  c.alu_op = core_pkg::OR;
          isa_pkg::F3_AND: c.alu_op = core_pkg::AND;
          default:         known = 1'b0; // slt, sltu
        endcase
        // alt funct7 only for sub and sra
        if (!f7_base && !(f7_alt && (inst.r.funct3 == isa_pkg::F3_ADD ||
                                     inst.r.funct3 == isa_pkg::F3_SRL))) begin
          known = 1'b0;
        end
      end
      isa_pkg::OP_IMM: begin
        c.reg_write = 1'b1;
        c.use_imm   = 1'b1;
        has_rd      = 1'b1;
        imm         = imm_i;
        case (inst.i.funct3)
          isa_pkg::F3_ADD: c.alu_op = core_pkg::ADD;
          isa_pkg::F3_XOR: c.alu_op = core_pkg::XOR;
          isa_pkg::F3_OR:  c.alu_op = core_pkg::OR;
          isa_pkg::F3_AND: c.alu_op = core_pkg::AND;
          isa_pkg::F3_SLL: begin
            c.alu_op = core_pkg::SLL;
            known    = f7_base;
          end
          isa_pkg::F3_SRL: begin
            c.alu_op = f7_alt ? core_pkg::SRA : core_pkg::SRL;
            known    = f7_base | f7_alt;
          end
          default:         known = 1'b0;
        endcase
      end
      isa_pkg::LOAD: begin
        c.use_imm     = 1'b1;
        c.mem_read    = 1'b1;
        c.reg_write   = 1'b1;
        c.wb_sel      = core_pkg::MEM;
        c.byte_access = inst.i.funct3 == isa_pkg::F3_LB;
        has_rd        = 1'b1;
        imm           = imm_i;
        known = inst.i.funct3 == isa_pkg::F3_LB || inst.i.funct3 == isa_pkg::F3_LW;
      end
      isa_pkg::STORE: begin
        c.use_imm     = 1'b1;
        c.mem_write   = 1'b1;
        c.byte_access = inst.s.funct3 == isa_pkg::F3_SB;
        imm           = imm_s;
        known = inst.s.funct3 == isa_pkg::F3_SB || inst.s.funct3 == isa_pkg::F3_SW;
      end
      isa_pkg::BRANCH: begin
        imm = imm_b;
        case (inst.b.funct3)
          isa_pkg::F3_BEQ:  c.branch = core_pkg::BEQ;
          isa_pkg::F3_BNE:  c.branch = core_pkg::BNE;
          isa_pkg::F3_BLT:  c.branch = core_pkg::BLT;
          isa_pkg::F3_BGE:  c.branch = core_pkg::BGE;
          isa_pkg::F3_BLTU: c.branch = core_pkg::BLTU;
          isa_pkg::F3_BGEU: c.branch = core_pkg::BGEU;
          default:          known = 1'b0;
        endcase
      end
      isa_pkg::LUI: begin
        c.alu_op    = core_pkg::PASS_B;
        c.use_imm   = 1'b1;
        c.reg_write = 1'b1;
        has_rd      = 1'b1;
        imm         = imm_u;
      end
      isa_pkg::AUIPC: begin
        c.pc_operand = 1'b1;
        c.use_imm    = 1'b1;
        c.reg_write  = 1'b1;
        has_rd       = 1'b1;
        imm          = imm_u;
      end
      isa_pkg::JAL: begin
        c.jump      = 1'b1;
        c.reg_write = 1'b1;
        c.wb_sel    = core_pkg::LINK;
        has_rd      = 1'b1;
        imm         = imm_j;
      end
      isa_pkg::JALR: begin
        c.jump      = 1'b1;
        c.jump_reg  = 1'b1;
        c.reg_write = 1'b1;
        c.wb_sel    = core_pkg::LINK;
        has_rd      = 1'b1;
        imm         = imm_i;
        known       = inst.i.funct3 == isa_pkg::F3_JALR;
      end
      default: known = 1'b0;
    endcase
  end

  assign ctrl = known ? c : core_pkg::ctrl_t'('0);
  assign rd   = (known && has_rd) ? inst.r.rd : '0; // zero for stores and branches
  assign rs1  = inst.r.rs1;
  assign rs2  = inst.r.rs2;

endmodule

`default_nettype wire

// File: src/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire core_pkg::ctrl_t      ctrl,
  input  wire [isa_pkg::XLEN-1:0]  pc,
  input  wire [isa_pkg::XLEN-1:0]  rs1_val,
  input  wire [isa_pkg::XLEN-1:0]  rs2_val,
  input  wire [isa_pkg::XLEN-1:0]  imm,
  output logic [isa_pkg::XLEN-1:0] alu_result,
  output logic [isa_pkg::XLEN-1:0] branch_target,
  output logic [isa_pkg::XLEN-1:0] link,
  output logic                     take_branch
);

  logic [isa_pkg::XLEN-1:0] op_a;
  logic [isa_pkg::XLEN-1:0] op_b;
  logic [isa_pkg::XLEN-1:0] reg_sum;
  logic [4:0]               shamt;
  logic                     cond;

  assign op_a  = ctrl.pc_operand ? pc : rs1_val;
  assign op_b  = ctrl.use_imm ? imm : rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      core_pkg::ADD:    alu_result = op_a + op_b;
      core_pkg::SUB:    alu_result = op_a - op_b;
      core_pkg::SLL:    alu_result = op_a << shamt;
      core_pkg::SRL:    alu_result = op_a >> shamt;
      core_pkg::SRA:    alu_result = $signed(op_a) >>> shamt;
      core_pkg::AND:    alu_result = op_a & op_b;
      core_pkg::OR:     alu_result = op_a | op_b;
      core_pkg::XOR:    alu_result = op_a ^ op_b;
      core_pkg::PASS_B: alu_result = op_b; // lui
      default:          alu_result = '0;
    endcase
  end

  // compares on the register values, not the alu
  always_comb begin
    case (ctrl.branch)
      core_pkg::BEQ:  cond = rs1_val == rs2_val;
      core_pkg::BNE:  cond = rs1_val != rs2_val;
      core_pkg::BLT:  cond = $signed(rs1_val) < $signed(rs2_val);
      core_pkg::BGE:  cond = $signed(rs1_val) >= $signed(rs2_val);
      core_pkg::BLTU: cond = rs1_val < rs2_val;
      core_pkg::BGEU: cond = rs1_val >= rs2_val;
      default:        cond = 1'b0;
    endcase
  end

  assign take_branch = cond | ctrl.jump;

  assign reg_sum       = rs1_val + imm;
  assign branch_target = ctrl.jump_reg ? {reg_sum[isa_pkg::XLEN-1:1], 1'b0} : pc + imm;
  assign link          = pc + 32'd4;

endmodule

`default_nettype wire

// File: src/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int XLEN = 32;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111
  } opcode_t;

  // funct3, alu ops
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101; // sra shares it
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  // funct3, memory and control flow
  localparam logic [2:0] F3_LB   = 3'b000;
  localparam logic [2:0] F3_LW   = 3'b010;
  localparam logic [2:0] F3_SB   = 3'b000;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [2:0] F3_JALR = 3'b000;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t          r;
    i_fmt_t          i;
    s_fmt_t          s;
    b_fmt_t          b;
    u_fmt_t          u;
    j_fmt_t          j;
    logic [XLEN-1:0] raw;
  } inst_u;

endpackage

`default_nettype wire

// File: src/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      busy,
  input  wire                      take_branch,
  input  wire [isa_pkg::XLEN-1:0]  branch_target,
  output logic [isa_pkg::XLEN-1:0] pc
);

  logic [isa_pkg::XLEN-1:0] pc_next;
  logic [isa_pkg::XLEN-1:0] pc_seq;

  assign pc_seq = pc + 32'd4;

  always_comb begin
    if (take_branch) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_seq;
    end
  end

  // hold through the first cycle of a memory access
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= '0;
    end else if (!busy) begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  wire                             clk,
  input  wire                             rst,
  input  wire [core_pkg::REG_ADDR_W-1:0]  rs1,
  input  wire [core_pkg::REG_ADDR_W-1:0]  rs2,
  input  wire [core_pkg::REG_ADDR_W-1:0]  rd,
  input  wire core_pkg::ctrl_t             ctrl,
  input  wire [isa_pkg::XLEN-1:0]         alu_result,
  input  wire [isa_pkg::XLEN-1:0]         load_data,
  input  wire [isa_pkg::XLEN-1:0]         link,
  input  wire                             busy,
  output logic [isa_pkg::XLEN-1:0]        rs1_val,
  output logic [isa_pkg::XLEN-1:0]        rs2_val,
  output logic [isa_pkg::XLEN-1:0]        wb_data
);

  logic [2**core_pkg::REG_ADDR_W-1:0][isa_pkg::XLEN-1:0] regs;
  logic                                                  we;

  assign rs1_val = regs[rs1];
  assign rs2_val = regs[rs2];

  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::MEM:  wb_data = load_data;
      core_pkg::LINK: wb_data = link;
      default:        wb_data = alu_result;
    endcase
    if (!ctrl.reg_write || rd == '0) wb_data = '0; // nothing written, report zero
  end

  assign we = ctrl.reg_write && !busy && rd != '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      regs <= '0;
    end else if (we) begin
      regs[rd] <= wb_data;
    end
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire                  clk,
  input  wire                  rst,
  input  wire core_pkg::prog_t  prog,
  output core_pkg::retire_t    retire
);

  logic [isa_pkg::XLEN-1:0]        pc;
  logic [isa_pkg::XLEN-1:0]        inst_word;
  core_pkg::ctrl_t                 ctrl;
  logic [core_pkg::REG_ADDR_W-1:0] rs1;
  logic [core_pkg::REG_ADDR_W-1:0] rs2;
  logic [core_pkg::REG_ADDR_W-1:0] rd;
  logic [isa_pkg::XLEN-1:0]        imm;
  logic [isa_pkg::XLEN-1:0]        rs1_val;
  logic [isa_pkg::XLEN-1:0]        rs2_val;
  logic [isa_pkg::XLEN-1:0]        wb_data;
  logic [isa_pkg::XLEN-1:0]        alu_result;
  logic [isa_pkg::XLEN-1:0]        branch_target;
  logic [isa_pkg::XLEN-1:0]        link;
  logic                            take_branch;
  logic [isa_pkg::XLEN-1:0]        load_data;
  logic                            busy;

  pc_unit u_pc (.clk(clk), .rst(rst), .busy(busy), .take_branch(take_branch),
                .branch_target(branch_target), .pc(pc));

  unified_memory u_mem (.clk(clk), .rst(rst), .prog(prog), .pc(pc), .addr(alu_result),
                        .store_data(rs2_val), .ctrl(ctrl), .inst(inst_word),
                        .load_data(load_data), .busy(busy));

  decode_unit u_dec (.inst(inst_word), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
                     .ctrl(ctrl));

  register_file u_rf (.clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .ctrl(ctrl),
                      .alu_result(alu_result), .load_data(load_data), .link(link),
                      .busy(busy), .rs1_val(rs1_val), .rs2_val(rs2_val),
                      .wb_data(wb_data));

  execute_unit u_ex (.ctrl(ctrl), .pc(pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
                     .imm(imm), .alu_result(alu_result), .branch_target(branch_target),
                     .link(link), .take_branch(take_branch));

  // retires when not stalled, never while held in reset
  assign retire.valid = ~busy & ~rst;
  assign retire.pc    = pc;
  assign retire.rd    = rd;
  assign retire.data  = wb_data;

endmodule

`default_nettype wire

// File: src/unified_memory.sv
`timescale 1ns/1ps
`default_nettype none

module unified_memory (
  input  wire                      clk,
  input  wire                      rst,
  input  wire core_pkg::prog_t      prog,
  input  wire [isa_pkg::XLEN-1:0]  pc,
  input  wire [isa_pkg::XLEN-1:0]  addr,
  input  wire [isa_pkg::XLEN-1:0]  store_data,
  input  wire core_pkg::ctrl_t      ctrl,
  output logic [isa_pkg::XLEN-1:0] inst,
  output logic [isa_pkg::XLEN-1:0] load_data,
  output logic                     busy
);

  logic [isa_pkg::XLEN-1:0]        mem [core_pkg::MEM_WORDS];
  logic [core_pkg::MEM_ADDR_W-1:0] data_idx;
  logic [4:0]                      lane_lsb;
  logic [isa_pkg::XLEN-1:0]        read_q;
  logic [7:0]                      lane_byte;
  logic                            access;
  logic                            second; // second cycle of an access

  assign inst     = mem[pc[core_pkg::MEM_ADDR_W+1:2]];
  assign data_idx = addr[core_pkg::MEM_ADDR_W+1:2];
  assign lane_lsb = {addr[1:0], 3'b000};

  assign access = ctrl.mem_read | ctrl.mem_write;
  assign busy   = access & ~second;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      second <= 1'b0;
    end else begin
      second <= busy;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      if (prog.we) mem[prog.addr] <= prog.data; // program load only in reset
    end else if (busy && ctrl.mem_write) begin
      if (ctrl.byte_access) begin
        mem[data_idx][lane_lsb +: 8] <= store_data[7:0];
      end else begin
        mem[data_idx] <= store_data;
      end
    end
    if (busy) read_q <= mem[data_idx];
  end

  assign lane_byte = read_q[lane_lsb +: 8];
  assign load_data = ctrl.byte_access ? {{(isa_pkg::XLEN-8){lane_byte[7]}}, lane_byte}
                                      : read_q;

  a_busy_one_cycle: assert property (@(posedge clk) disable iff (rst) busy |=> !busy)
    else $error("busy held for two cycles");

endmodule

`default_nettype wire

// File: include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

  // opcodes for the words built with i_type and u_type
  localparam int OPC_IMM   = 'h13;
  localparam int OPC_LOAD  = 'h03;
  localparam int OPC_LUI   = 'h37;
  localparam int OPC_AUIPC = 'h17;
  localparam int OPC_JALR  = 'h67;

  localparam int PROG_LEN  = 37;
  localparam int TRACE_LEN = 31;

  typedef struct packed {
    logic [isa_pkg::XLEN-1:0]        pc;
    logic [core_pkg::REG_ADDR_W-1:0] rd;
    logic [isa_pkg::XLEN-1:0]        data;
  } trace_row_t;

  logic [isa_pkg::XLEN-1:0] prog_image [PROG_LEN];
  trace_row_t               trace [TRACE_LEN];

  // one word per instruction from address 0, data area at 0x200
  task automatic fill_program;
    prog_image[0]  = i_type(OPC_IMM, 0, 1, 0, 5);       // addi x1, x0, 5
    prog_image[1]  = i_type(OPC_IMM, 0, 2, 0, -3);      // addi x2, x0, -3
    prog_image[2]  = u_type(OPC_LUI, 3, 'h12345);       // lui x3, 0x12345
    prog_image[3]  = i_type(OPC_IMM, 0, 3, 3, 'h678);   // addi x3, x3, 0x678
    prog_image[4]  = r_type(0, 2, 1, 0, 4);             // add x4, x1, x2
    prog_image[5]  = r_type('h20, 2, 1, 0, 5);          // sub x5, x1, x2
    prog_image[6]  = r_type(0, 5, 3, 7, 6);             // and x6, x3, x5
    prog_image[7]  = r_type(0, 1, 3, 6, 7);             // or x7, x3, x1
    prog_image[8]  = r_type(0, 2, 3, 4, 8);             // xor x8, x3, x2
    prog_image[9]  = r_type(0, 1, 3, 1, 9);             // sll x9, x3, x1
    prog_image[10] = r_type(0, 1, 2, 5, 10);            // srl x10, x2, x1
    prog_image[11] = r_type('h20, 1, 2, 5, 11);         // sra x11, x2, x1
    prog_image[12] = i_type(OPC_IMM, 0, 12, 0, 'h200);  // addi x12, x0, 0x200
    prog_image[13] = s_type(2, 12, 3, 0);               // sw x3, 0(x12)
    prog_image[14] = i_type(OPC_LOAD, 2, 13, 12, 0);    // lw x13, 0(x12)
    prog_image[15] = i_type(OPC_IMM, 0, 14, 0, 'hA5);   // addi x14, x0, 0xa5
    prog_image[16] = s_type(0, 12, 14, 2);              // sb x14, 2(x12)
    prog_image[17] = i_type(OPC_LOAD, 0, 15, 12, 2);    // lb x15, 2(x12)
    prog_image[18] = i_type(OPC_LOAD, 2, 16, 12, 0);    // lw x16, 0(x12)
    prog_image[19] = b_type(0, 1, 1, 8);                // beq x1, x1, +8
    prog_image[20] = i_type(OPC_IMM, 0, 17, 0, 1);      // skipped
    prog_image[21] = b_type(6, 1, 2, 8);                // bltu x1, x2, +8
    prog_image[22] = i_type(OPC_IMM, 0, 17, 0, 2);      // skipped
    prog_image[23] = b_type(5, 2, 1, 8);                // bge x2, x1, +8
    prog_image[24] = b_type(4, 1, 2, 8);                // blt x1, x2, +8
    prog_image[25] = i_type(OPC_IMM, 0, 17, 0, 3);      // addi x17, x0, 3
    prog_image[26] = j_type(18, 12);                    // jal x18, +12
    prog_image[27] = i_type(OPC_IMM, 0, 17, 0, 4);
    prog_image[28] = i_type(OPC_IMM, 0, 17, 0, 5);
    prog_image[29] = u_type(OPC_AUIPC, 19, 1);          // auipc x19, 0x1
    prog_image[30] = i_type(OPC_IMM, 0, 20, 0, 'h88);   // addi x20, x0, 0x88
    prog_image[31] = i_type(OPC_JALR, 0, 21, 20, 1);    // jalr x21, 1(x20)
    prog_image[32] = i_type(OPC_IMM, 0, 17, 0, 6);
    prog_image[33] = i_type(OPC_IMM, 0, 17, 0, 7);
    prog_image[34] = i_type(OPC_IMM, 0, 0, 1, 7);       // addi x0, x1, 7
    prog_image[35] = r_type(0, 1, 0, 0, 22);            // add x22, x0, x1
    prog_image[36] = j_type(0, 0);                      // jal x0, 0 spins here
  endtask

  // retirements in order as pc, rd, data
  task automatic fill_trace;
    trace[0]  = trace_row_t'{32'h0000_0000, 5'd1,  32'h0000_0005};
    trace[1]  = trace_row_t'{32'h0000_0004, 5'd2,  32'hFFFF_FFFD};
    trace[2]  = trace_row_t'{32'h0000_0008, 5'd3,  32'h1234_5000};
    trace[3]  = trace_row_t'{32'h0000_000C, 5'd3,  32'h1234_5678};
    trace[4]  = trace_row_t'{32'h0000_0010, 5'd4,  32'h0000_0002};
    trace[5]  = trace_row_t'{32'h0000_0014, 5'd5,  32'h0000_0008};
    trace[6]  = trace_row_t'{32'h0000_0018, 5'd6,  32'h0000_0008};
    trace[7]  = trace_row_t'{32'h0000_001C, 5'd7,  32'h1234_567D};
    trace[8]  = trace_row_t'{32'h0000_0020, 5'd8,  32'hEDCB_A985};
    trace[9]  = trace_row_t'{32'h0000_0024, 5'd9,  32'h468A_CF00};
    trace[10] = trace_row_t'{32'h0000_0028, 5'd10, 32'h07FF_FFFF};
    trace[11] = trace_row_t'{32'h0000_002C, 5'd11, 32'hFFFF_FFFF};
    trace[12] = trace_row_t'{32'h0000_0030, 5'd12, 32'h0000_0200};
    trace[13] = trace_row_t'{32'h0000_0034, 5'd0,  32'h0000_0000}; // sw
    trace[14] = trace_row_t'{32'h0000_0038, 5'd13, 32'h1234_5678};
    trace[15] = trace_row_t'{32'h0000_003C, 5'd14, 32'h0000_00A5};
    trace[16] = trace_row_t'{32'h0000_0040, 5'd0,  32'h0000_0000}; // sb
    trace[17] = trace_row_t'{32'h0000_0044, 5'd15, 32'hFFFF_FFA5};
    trace[18] = trace_row_t'{32'h0000_0048, 5'd16, 32'h12A5_5678}; // lanes 0, 1, 3 kept
    trace[19] = trace_row_t'{32'h0000_004C, 5'd0,  32'h0000_0000};
    trace[20] = trace_row_t'{32'h0000_0054, 5'd0,  32'h0000_0000};
    trace[21] = trace_row_t'{32'h0000_005C, 5'd0,  32'h0000_0000};
    trace[22] = trace_row_t'{32'h0000_0060, 5'd0,  32'h0000_0000};
    trace[23] = trace_row_t'{32'h0000_0064, 5'd17, 32'h0000_0003};
    trace[24] = trace_row_t'{32'h0000_0068, 5'd18, 32'h0000_006C};
    trace[25] = trace_row_t'{32'h0000_0074, 5'd19, 32'h0000_1074};
    trace[26] = trace_row_t'{32'h0000_0078, 5'd20, 32'h0000_0088};
    trace[27] = trace_row_t'{32'h0000_007C, 5'd21, 32'h0000_0080};
    trace[28] = trace_row_t'{32'h0000_0088, 5'd0,  32'h0000_0000};
    trace[29] = trace_row_t'{32'h0000_008C, 5'd22, 32'h0000_0005};
    trace[30] = trace_row_t'{32'h0000_0090, 5'd0,  32'h0000_0000};
  endtask

`endif

// File: test/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int MIN_RESET    = 16;
  localparam int SAMPLE_DELAY = 1; // ns after the falling edge
  localparam int OPC_STORE    = 'h23; // sw and sb

  logic              clk;
  logic              rst;
  core_pkg::prog_t   prog;
  core_pkg::retire_t retire;

  int word_errors;
  int reg_errors;
  int other_errors;
  int rows_done;
  int stall_cycles;

  rv_core DUT (.clk(clk), .rst(rst), .prog(prog), .retire(retire));

  // arguments follow the field order of each format
  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input int op, input int f3, input int rd,
                                         input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] s_type(input int f3, input int rs1, input int rs2,
                                         input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input int op, input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] j_type(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  `include "tb_program.svh"

  // the whole image goes in while rst is high
  localparam int RESET_CYCLES   = (PROG_LEN > MIN_RESET) ? PROG_LEN : MIN_RESET;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * TRACE_LEN + 4;

  task automatic check_word(input string what, input logic [isa_pkg::XLEN-1:0] got,
                            input logic [isa_pkg::XLEN-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      word_errors++;
    end
  endtask

  task automatic check_reg(input string what, input logic [core_pkg::REG_ADDR_W-1:0] got,
                           input logic [core_pkg::REG_ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
      reg_errors++;
    end
  endtask

  task automatic compare_row(input int idx);
    check_word($sformatf("row %0d pc", idx), retire.pc, trace[idx].pc);
    check_reg($sformatf("row %0d rd", idx), retire.rd, trace[idx].rd);
    check_word($sformatf("row %0d data", idx), retire.data, trace[idx].data);
  endtask

  // a load or a store spends one cycle with retire low before it retires
  task automatic check_stall(input int idx, input int stalls);
    int opc;
    int exp_stalls;
    opc        = prog_image[trace[idx].pc[isa_pkg::XLEN-1:2]][6:0];
    exp_stalls = (opc == OPC_LOAD || opc == OPC_STORE) ? 1 : 0;
    if (stalls != exp_stalls) begin
      $display("[FAIL] %0t ns: row %0d retired after %0d stall cycles, expected %0d",
               $time, idx, stalls, exp_stalls);
      other_errors++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst          = 1'b1;
    prog         = '0;
    word_errors  = 0;
    reg_errors   = 0;
    other_errors = 0;
    rows_done    = 0;
    stall_cycles = 0;
    fill_program();
    fill_trace();
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
      if (retire.valid !== 1'b0 || retire.pc !== '0) begin
        $display("[FAIL] %0t ns: retire active or pc nonzero during reset", $time);
        other_errors++;
      end
      if (i < PROG_LEN) begin
        prog.we   = 1'b1;
        prog.addr = i[core_pkg::MEM_ADDR_W-1:0];
        prog.data = prog_image[i];
      end else begin
        prog = '0;
      end
    end
    @(negedge clk);
    rst  = 1'b0;
    prog = '0;
    // one sample per cycle, well before the retiring edge
    while (rows_done < TRACE_LEN) begin
      #(SAMPLE_DELAY);
      if (retire.valid === 1'b1) begin
        compare_row(rows_done);
        check_stall(rows_done, stall_cycles);
        stall_cycles = 0;
        rows_done++;
      end else begin
        stall_cycles++;
      end
      @(negedge clk);
    end
    $display("errors: %0d word, %0d register, %0d other", word_errors, reg_errors,
             other_errors);
    if (word_errors + reg_errors + other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("timeout: only %0d of %0d retirements seen, the core appears hung",
             rows_done, TRACE_LEN);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
